/* verilog/mem_pkg.sv */
package mem_pkg;

    // Memory geometry
    localparam int MEM_BYTES   = 256;               // One word per four bytes
    localparam int ADDR_W      = $clog2(MEM_BYTES); // Byte address width
    localparam int DATA_W      = 32;
    localparam int MEM_WORDS   = MEM_BYTES / 4;     // Entries per byte lane
    localparam int WORD_ADDR_W = ADDR_W - 2;        // Address of one aligned word

    // Load funct3 codes
    localparam logic [2:0] F3_LB  = 3'd0;
    localparam logic [2:0] F3_LH  = 3'd1;
    localparam logic [2:0] F3_LW  = 3'd2;
    localparam logic [2:0] F3_LBU = 3'd4;
    localparam logic [2:0] F3_LHU = 3'd5;

    // Store funct3 codes
    localparam logic [2:0] F3_SB  = 3'd0;
    localparam logic [2:0] F3_SH  = 3'd1;
    localparam logic [2:0] F3_SW  = 3'd2;

    // Access width of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

endpackage

/* verilog/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if import mem_pkg::*; ();

    logic                   req;        // Access strobe, one cycle
    logic                   we;         // Store when high, load when low
    logic [3:0]             byte_en;    // Lanes written by a store
    logic [WORD_ADDR_W-1:0] word_addr;
    logic [DATA_W-1:0]      wdata;      // Already shifted into its lanes
    mem_size_e              size;
    logic                   is_signed;
    logic [1:0]             offset;     // Byte offset inside the word
    logic                   misaligned; // Refused access, req stays low

    modport dec (
        output req, we, byte_en, word_addr, wdata,
        output size, is_signed, offset, misaligned
    );

    modport mem (
        input req, we, byte_en, word_addr, wdata,
        input size, is_signed, offset, misaligned
    );

endinterface

/* verilog/load_if.sv */
`timescale 1ns/1ps

interface load_if import mem_pkg::*; ();

    logic              valid;     // Pulse one cycle after an accepted load
    logic [DATA_W-1:0] rdata;     // Raw aligned word
    mem_size_e         size;
    logic              is_signed;
    logic [1:0]        offset;
    logic              err;       // Pulse one cycle after a refused access

    modport mem (
        output valid, rdata, size, is_signed, offset, err
    );

    modport res (
        input valid, rdata, size, is_signed, offset, err
    );

endinterface

/* verilog/mem_access_decode.sv */
`timescale 1ns/1ps

module mem_access_decode import mem_pkg::*; (
    input  logic              i_valid,
    input  logic              i_stall,
    input  logic              i_mem_read,
    input  logic              i_mem_write,
    input  logic              i_branch,
    input  logic              i_zero_alu,
    input  logic [2:0]        i_funct3,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_write_data,
    output logic              o_pc_source,
    mem_req_if.dec            req
);

    mem_size_e  size;
    logic       is_signed;
    logic       aligned;
    logic       access;   // Valid, unstalled, exactly one of read or write
    logic [1:0] offset;

    assign offset = i_addr[1:0];
    assign access = i_valid && !i_stall && (i_mem_read ^ i_mem_write);

    // Width and signedness from funct3
    always_comb begin
        size      = SIZE_WORD;
        is_signed = 1'b0;
        if (i_mem_write) begin
            case (i_funct3)
                F3_SB:   size = SIZE_BYTE;
                F3_SH:   size = SIZE_HALF;
                F3_SW:   size = SIZE_WORD;
                default: size = SIZE_WORD;
            endcase
        end else begin
            case (i_funct3)
                F3_LB: begin
                    size      = SIZE_BYTE;
                    is_signed = 1'b1;
                end
                F3_LH: begin
                    size      = SIZE_HALF;
                    is_signed = 1'b1;
                end
                F3_LW:   size = SIZE_WORD;
                F3_LBU:  size = SIZE_BYTE;
                F3_LHU:  size = SIZE_HALF;
                default: size = SIZE_WORD; // Unknown codes act as a plain word
            endcase
        end
    end

    always_comb begin
        case (size)
            SIZE_BYTE: aligned = 1'b1;
            SIZE_HALF: aligned = !offset[0];
            default:   aligned = (offset == 2'b00);
        endcase
    end

    // Lanes touched by a store
    always_comb begin
        case (size)
            SIZE_BYTE: req.byte_en = 4'b0001 << offset;
            SIZE_HALF: req.byte_en = 4'b0011 << offset;
            default:   req.byte_en = 4'b1111;
        endcase
    end

    assign req.wdata      = i_write_data << {offset, 3'b000}; // Move data to its lanes
    assign req.req        = access && aligned;
    assign req.misaligned = access && !aligned;
    assign req.we         = i_mem_write;
    assign req.word_addr  = i_addr[ADDR_W-1:2];
    assign req.size       = size;
    assign req.is_signed  = is_signed;
    assign req.offset     = offset;

    assign o_pc_source = i_branch && i_zero_alu && i_valid && !i_stall;

endmodule

/* verilog/data_memory.sv */
`timescale 1ns/1ps

module data_memory import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    mem_req_if.mem            req,
    input  logic              i_debug_en,
    input  logic [ADDR_W-1:0] i_debug_addr,
    output logic [DATA_W-1:0] o_debug_data,
    load_if.mem               ld
);

    logic [DATA_W-1:0]      rd_word;    // Word at the request address
    logic [DATA_W-1:0]      dbg_word;   // Word at the debug address
    logic [WORD_ADDR_W-1:0] dbg_waddr;
    logic                   rd_accept;

    assign dbg_waddr = i_debug_addr[ADDR_W-1:2];
    assign rd_accept = req.req && !req.we;

    // One memory per byte lane, little endian
    for (genvar ln = 0; ln < 4; ln++) begin : g_lane
        logic [7:0] lane_mem [MEM_WORDS];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int w = 0; w < MEM_WORDS; w++) begin
                    lane_mem[w] <= '0;
                end
            end else if (req.req && req.we && req.byte_en[ln]) begin
                lane_mem[req.word_addr] <= req.wdata[8*ln +: 8];
            end
        end

        assign rd_word[8*ln +: 8]  = lane_mem[req.word_addr];
        assign dbg_word[8*ln +: 8] = lane_mem[dbg_waddr];
    end

    // Pulses for the result stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ld.valid <= 1'b0;
            ld.err   <= 1'b0;
        end else begin
            ld.valid <= rd_accept;
            ld.err   <= req.misaligned;
        end
    end

    // Load word and its attributes, held until the next accepted load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ld.rdata     <= '0;
            ld.size      <= SIZE_BYTE;
            ld.is_signed <= 1'b0;
            ld.offset    <= 2'b00;
        end else if (rd_accept) begin
            ld.rdata     <= rd_word;
            ld.size      <= req.size;
            ld.is_signed <= req.is_signed;
            ld.offset    <= req.offset;
        end
    end

    // Debug read holds until the next request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_debug_data <= '0;
        end else if (i_debug_en) begin
            o_debug_data <= dbg_word;
        end
    end

endmodule

/* verilog/load_align.sv */
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
    load_if.res               ld,
    output logic              o_load_valid,
    output logic              o_misaligned,
    output logic [DATA_W-1:0] o_load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Byte lane picked by the offset
    assign sel_byte = ld.rdata[{ld.offset, 3'b000} +: 8];

    // Halfwords only sit at offset 0 or 2
    assign sel_half = ld.offset[1] ? ld.rdata[31:16] : ld.rdata[15:0];

    always_comb begin
        case (ld.size)
            SIZE_BYTE: begin
                if (ld.is_signed) begin
                    o_load_data = {{24{sel_byte[7]}}, sel_byte};
                end else begin
                    o_load_data = {24'b0, sel_byte};
                end
            end
            SIZE_HALF: begin
                if (ld.is_signed) begin
                    o_load_data = {{16{sel_half[15]}}, sel_half};
                end else begin
                    o_load_data = {16'b0, sel_half};
                end
            end
            default: o_load_data = ld.rdata; // Full word as read
        endcase
    end

    assign o_load_valid = ld.valid;
    assign o_misaligned = ld.err;

endmodule

/* verilog/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // Request from execute
    input  logic              i_valid,
    input  logic              i_stall,
    input  logic              i_mem_read,
    input  logic              i_mem_write,
    input  logic [2:0]        i_funct3,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_write_data,
    // Branch resolution
    input  logic              i_branch,
    input  logic              i_zero_alu,
    output logic              o_pc_source,
    // Debug port
    input  logic              i_debug_en,
    input  logic [ADDR_W-1:0] i_debug_addr,
    output logic [DATA_W-1:0] o_debug_data,
    // Load result
    output logic              o_load_valid,
    output logic              o_misaligned,
    output logic [DATA_W-1:0] o_load_data
);

    mem_req_if u_req ();
    load_if    u_ld ();

    mem_access_decode u_decode (
        .i_valid      (i_valid),
        .i_stall      (i_stall),
        .i_mem_read   (i_mem_read),
        .i_mem_write  (i_mem_write),
        .i_branch     (i_branch),
        .i_zero_alu   (i_zero_alu),
        .i_funct3     (i_funct3),
        .i_addr       (i_addr),
        .i_write_data (i_write_data),
        .o_pc_source  (o_pc_source),
        .req          (u_req)
    );

    data_memory u_mem (
        .clk          (clk),
        .rst          (rst),
        .req          (u_req),
        .i_debug_en   (i_debug_en),
        .i_debug_addr (i_debug_addr),
        .o_debug_data (o_debug_data),
        .ld           (u_ld)
    );

    load_align u_align (
        .ld           (u_ld),
        .o_load_valid (o_load_valid),
        .o_misaligned (o_misaligned),
        .o_load_data  (o_load_data)
    );

endmodule

/* testbench/mem_stage_props.sv */
`timescale 1ns/1ps

module mem_stage_props import mem_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              i_valid,
    input logic              i_stall,
    input logic              i_mem_read,
    input logic              i_mem_write,
    input logic [2:0]        i_funct3,
    input logic [ADDR_W-1:0] i_addr,
    input logic              o_load_valid,
    input logic              o_misaligned
);

    int   fail_count = 0;
    logic align_ok;
    logic rd_ok;      // Read accepted at this edge

    always_comb begin
        case (i_funct3[1:0])
            2'd0:    align_ok = 1'b1;
            2'd1:    align_ok = !i_addr[0];
            default: align_ok = (i_addr[1:0] == 2'b00);
        endcase
    end

    assign rd_ok = i_valid && !i_stall && i_mem_read && !i_mem_write && align_ok;

    a_pulse_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_load_valid && o_misaligned))
        else begin
            $error("load valid and misaligned pulses high together");
            fail_count++;
        end

    a_valid_src: assert property (@(posedge clk) disable iff (rst)
        o_load_valid |-> $past(rd_ok))
        else begin
            $error("load valid without an accepted read one cycle earlier");
            fail_count++;
        end

    a_rst_quiet: assert property (@(posedge clk) rst |-> (!o_load_valid && !o_misaligned))
        else begin
            $error("result pulse high during reset");
            fail_count++;
        end

endmodule

bind mem_stage_top mem_stage_props u_props (
    .clk          (clk),
    .rst          (rst),
    .i_valid      (i_valid),
    .i_stall      (i_stall),
    .i_mem_read   (i_mem_read),
    .i_mem_write  (i_mem_write),
    .i_funct3     (i_funct3),
    .i_addr       (i_addr),
    .o_load_valid (o_load_valid),
    .o_misaligned (o_misaligned)
);

/* testbench/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int MAX_CYCLES = 5000;
    localparam int N_RANDOM   = 400;

    logic              clk = 1'b0;
    logic              rst;
    logic              i_valid;
    logic              i_stall;
    logic              i_mem_read;
    logic              i_mem_write;
    logic [2:0]        i_funct3;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_write_data;
    logic              i_branch;
    logic              i_zero_alu;
    logic              o_pc_source;
    logic              i_debug_en;
    logic [ADDR_W-1:0] i_debug_addr;
    logic [DATA_W-1:0] o_debug_data;
    logic              o_load_valid;
    logic              o_misaligned;
    logic [DATA_W-1:0] o_load_data;

    logic [7:0]        ref_mem [MEM_BYTES];  // Little-endian byte model
    logic [31:0]       lfsr_state = 32'he54ca4ae;
    logic [2:0]        load_codes [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
    logic              pend_valid = 1'b0;    // Expected after the coming edge
    logic              pend_mis   = 1'b0;
    logic [DATA_W-1:0] pend_data  = '0;
    logic [DATA_W-1:0] pend_debug = '0;
    logic              exp_valid  = 1'b0;    // Expected in the current cycle
    logic              exp_mis    = 1'b0;
    logic [DATA_W-1:0] exp_data   = '0;
    logic [DATA_W-1:0] exp_debug  = '0;
    logic              checking   = 1'b0;
    int                error_count = 0;

    mem_stage_top DUT (.*);

    always #10 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // funct3[1:0] gives byte, half or word for loads and stores alike
    function automatic logic addr_aligned(input logic [2:0] f3, input logic [ADDR_W-1:0] a);
        case (f3[1:0])
            2'd0:    return 1'b1;
            2'd1:    return !a[0];
            default: return a[1:0] == 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [ADDR_W-1:0] a);
        return {ref_mem[{a[ADDR_W-1:2], 2'd3}], ref_mem[{a[ADDR_W-1:2], 2'd2}],
                ref_mem[{a[ADDR_W-1:2], 2'd1}], ref_mem[{a[ADDR_W-1:2], 2'd0}]};
    endfunction

    // Expected load result from the byte model
    function automatic logic [31:0] load_result(input logic [2:0]        f3,
                                                input logic [ADDR_W-1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[{a[ADDR_W-1:1], 1'b1}], ref_mem[{a[ADDR_W-1:1], 1'b0}]};
        case (f3)
            F3_LB:   return {{24{b[7]}}, b};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LBU:  return {24'b0, b};
            F3_LHU:  return {16'b0, h};
            default: return model_word(a);
        endcase
    endfunction

    task automatic update_model(input logic [2:0] f3, input logic [ADDR_W-1:0] a,
                                input logic [DATA_W-1:0] d);
        int nbytes;
        nbytes = (f3[1:0] == 2'd0) ? 1 : ((f3[1:0] == 2'd1) ? 2 : 4);
        for (int k = 0; k < nbytes; k++) begin
            ref_mem[a + ADDR_W'(k)] = d[8*k +: 8];
        end
    endtask

    // One cycle of stimulus with expectations from the acceptance rule
    task automatic drive_cycle(
        input logic              v,
        input logic              st,
        input logic              rd,
        input logic              wr,
        input logic [2:0]        f3,
        input logic [ADDR_W-1:0] a,
        input logic [DATA_W-1:0] d,
        input logic              dbg,
        input logic [ADDR_W-1:0] da
    );
        logic attempt;
        logic accept;
        @(posedge clk);
        #2;
        i_valid      = v;
        i_stall      = st;
        i_mem_read   = rd;
        i_mem_write  = wr;
        i_funct3     = f3;
        i_addr       = a;
        i_write_data = d;
        i_debug_en   = dbg;
        i_debug_addr = da;
        i_branch     = rand_bits(1) != 0;
        i_zero_alu   = rand_bits(1) != 0;
        attempt      = v && !st && (rd ^ wr);
        accept       = attempt && addr_aligned(f3, a);
        pend_valid   = accept && rd;
        pend_mis     = attempt && !accept;
        if (accept && rd) begin
            pend_data = load_result(f3, a);
        end
        if (dbg) begin
            pend_debug = model_word(da); // Old contents since a store this cycle lands later
        end
        if (accept && wr) begin
            update_model(f3, a, d);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 3'd0, '0, '0, 1'b0, '0);
    endtask

    task automatic debug_read(input logic [ADDR_W-1:0] a);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 3'd0, '0, '0, 1'b1, a);
    endtask

    // Move expectations into the cycle they belong to
    always @(posedge clk) begin
        exp_valid  = pend_valid;
        exp_mis    = pend_mis;
        exp_data   = pend_data;
        exp_debug  = pend_debug;
        pend_valid = 1'b0;
        pend_mis   = 1'b0;
    end

    always @(negedge clk) begin
        logic exp_pc;
        exp_pc = i_branch && i_zero_alu && i_valid && !i_stall;
        if (checking) begin
            assert (o_load_valid === exp_valid) else begin
                $display("Mismatch at %0t: o_load_valid expected %0b got %0b",
                         $time, exp_valid, o_load_valid);
                error_count++;
            end
            assert (o_misaligned === exp_mis) else begin
                $display("Mismatch at %0t: o_misaligned expected %0b got %0b",
                         $time, exp_mis, o_misaligned);
                error_count++;
            end
            if (exp_valid) begin
                assert (o_load_data === exp_data) else begin
                    $display("Mismatch at %0t: o_load_data expected %08h got %08h",
                             $time, exp_data, o_load_data);
                    error_count++;
                end
            end
            assert (o_debug_data === exp_debug) else begin
                $display("Mismatch at %0t: o_debug_data expected %08h got %08h",
                         $time, exp_debug, o_debug_data);
                error_count++;
            end
            assert (o_pc_source === exp_pc) else begin
                $display("Mismatch at %0t: o_pc_source expected %0b got %0b",
                         $time, exp_pc, o_pc_source);
                error_count++;
            end
        end
    end

    // Watchdog
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("Timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] a;
        logic [2:0]        f3;
        logic [1:0]        off;
        logic              wr;
        rst          = 1'b1;
        i_valid      = 1'b0;
        i_stall      = 1'b0;
        i_mem_read   = 1'b0;
        i_mem_write  = 1'b0;
        i_funct3     = 3'd0;
        i_addr       = '0;
        i_write_data = '0;
        i_branch     = 1'b0;
        i_zero_alu   = 1'b0;
        i_debug_en   = 1'b0;
        i_debug_addr = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #2 rst = 1'b0;
        checking = 1'b1;

        // Memory reads zero after reset
        for (int w = 0; w < MEM_WORDS; w += 3) begin
            debug_read(ADDR_W'(4 * w));
        end

        // Random aligned stores and loads in the low 64 bytes
        for (int n = 0; n < N_RANDOM; n++) begin
            a = ADDR_W'(rand_bits(6));
            if (rand_bits(1) != 0) begin
                f3 = 3'(rand_bits(2) % 3);
                a  = f3[1] ? {a[ADDR_W-1:2], 2'b00} : (f3[0] ? {a[ADDR_W-1:1], 1'b0} : a);
                drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, f3, a, rand_bits(32),
                            rand_bits(1) != 0, ADDR_W'(rand_bits(6)));
            end else begin
                f3 = load_codes[rand_bits(3) % 5];
                a  = (f3[1:0] == 2'd2) ? {a[ADDR_W-1:2], 2'b00} :
                     ((f3[1:0] == 2'd1) ? {a[ADDR_W-1:1], 1'b0} : a);
                drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, f3, a, '0,
                            rand_bits(1) != 0, ADDR_W'(rand_bits(6)));
            end
        end

        // Misaligned half and word accesses each followed by a debug read
        for (int n = 0; n < 40; n++) begin
            a  = ADDR_W'(rand_bits(6));
            wr = rand_bits(1) != 0;
            if (rand_bits(1) != 0) begin
                f3 = wr ? F3_SH : ((rand_bits(1) != 0) ? F3_LH : F3_LHU);
                a  = {a[ADDR_W-1:1], 1'b1};
            end else begin
                f3  = F3_LW;
                off = 2'(rand_bits(2));
                a   = {a[ADDR_W-1:2], (off == 2'b00) ? 2'b10 : off};
            end
            drive_cycle(1'b1, 1'b0, !wr, wr, f3, a, rand_bits(32), 1'b0, '0);
            debug_read(a);
        end

        // Stalled requests are ignored
        for (int n = 0; n < 30; n++) begin
            a  = {ADDR_W'(rand_bits(6))} & ~ADDR_W'(3);
            wr = rand_bits(1) != 0;
            drive_cycle(1'b1, 1'b1, !wr, wr, F3_SW, a, rand_bits(32), 1'b0, '0);
            debug_read(a);
        end

        // Full debug sweep against the model
        for (int w = 0; w < MEM_WORDS; w++) begin
            debug_read(ADDR_W'(4 * w));
        end

        // Branch resolution with random valid and stall
        for (int n = 0; n < 50; n++) begin
            drive_cycle(rand_bits(1) != 0, rand_bits(1) != 0, 1'b0, 1'b0, 3'd0, '0, '0,
                        1'b0, '0);
        end
        idle_cycle();
        idle_cycle();
        @(negedge clk);
        #1;

        $display("Errors: %0d check failures, %0d property failures",
                 error_count, DUT.u_props.fail_count);
        if (error_count == 0 && DUT.u_props.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/mem_pkg.sv
verilog/mem_req_if.sv
verilog/load_if.sv
verilog/mem_access_decode.sv
verilog/data_memory.sv
verilog/load_align.sv
verilog/mem_stage_top.sv
testbench/mem_stage_props.sv
testbench/tb_mem_stage.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_mem_stage
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
